/* demosaicGreen.f */
rtl/demosaicPkg.sv
rtl/bayerWindowIf.sv
rtl/rasterCounter.sv
rtl/bayerWindow.sv
rtl/greenEstimator.sv
rtl/activityThreshold.sv
rtl/demosaicGreen.sv
tests/demosaicGreen_assert.sv
tests/demosaicGreenTb.sv

/* rtl/activityThreshold.sv */
module activityThreshold
	import demosaicPkg::*;
(
	input logic clk,
	input logic reset,
	input ActivityT activitySample,
	input logic sampleValid,
	input logic frameDone,
	output ThresholdT threshold
);

	ActivityT activitySum;

	// First bound the sum stays below picks the level
	function automatic ThresholdT levelFor(ActivityT sum);
		ThresholdT level;
		level = ThresholdLevel[4];
		for (int i = 3; i >= 0; i--) begin
			if (sum < ActivityBound[i]) begin
				level = ThresholdLevel[i];
			end
		end
		return level;
	endfunction

	// Last sample of a frame always lands before its frameDone
	always_ff @(posedge clk) begin
		if (reset) begin
			activitySum <= '0;
			threshold <= ThresholdT'(ThresholdReset);
		end else if (frameDone) begin
			threshold <= levelFor(activitySum);
			activitySum <= '0;
		end else if (sampleValid) begin
			activitySum <= activitySum + activitySample;
		end
	end

endmodule

/* rtl/bayerWindow.sv */
module bayerWindow
	import demosaicPkg::*;
#(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080
) (
	input logic clk,
	input logic reset,
	input PixelT bayer,
	input logic bayerValid,
	input CoordT centerX,
	input CoordT centerY,
	input logic centerValid,
	input logic frameEnd,
	bayerWindowIf.source win
);

	localparam int PtrBits = (frameWidth > 1) ? $clog2(frameWidth) : 1;

	// One column of the previous row [0] and the row before it [1]
	PixelT [1:0] rowMem [frameWidth];
	PixelT [1:0] rowOut;
	logic [PtrBits-1:0] rowPtr;
	PixelT [2:0] tap;

	// Unmasked window, row 0 and column 0 hold the newest pixels
	PixelT [2:0][2:0] raw;

	logic atTop;
	logic atBottom;
	logic atLeft;
	logic atRight;
	SiteT site;

	assign rowOut = rowMem[rowPtr];
	assign tap[0] = bayer;
	assign tap[1] = rowOut[0];
	assign tap[2] = rowOut[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			rowPtr <= '0;
		end else if (bayerValid) begin
			if (rowPtr == PtrBits'(frameWidth - 1)) begin
				rowPtr <= '0;
			end else begin
				rowPtr <= rowPtr + 1'b1;
			end
		end
	end

	// Read before write gives exactly one row of delay per stage
	always_ff @(posedge clk) begin
		if (bayerValid) begin
			rowMem[rowPtr] <= {rowOut[0], bayer};
			for (int r = 0; r < 3; r++) begin
				raw[r] <= {raw[r][1:0], tap[r]};
			end
		end
	end

	assign atTop = (centerY == '0);
	assign atBottom = (centerY == CoordT'(frameHeight - 1));
	assign atLeft = (centerX == '0);
	assign atRight = (centerX == CoordT'(frameWidth - 1));

	// Green on equal parity, blue on even rows, red on odd rows
	always_comb begin
		if (centerX[0] == centerY[0]) begin
			site = SiteGreen;
		end else if (!centerY[0]) begin
			site = SiteBlue;
		end else begin
			site = SiteRed;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			win.valid <= 1'b0;
			win.frameEnd <= 1'b0;
		end else if (bayerValid) begin
			win.valid <= centerValid;
			win.frameEnd <= frameEnd;
		end
	end

	// Flip to top-left order and zero whatever lies outside the frame
	always_ff @(posedge clk) begin
		if (bayerValid) begin
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					if ((i == 0 && atTop) || (i == 2 && atBottom) ||
						(j == 0 && atLeft) || (j == 2 && atRight)) begin
						win.window[i][j] <= '0;
					end else begin
						win.window[i][j] <= raw[2 - i][2 - j];
					end
				end
			end
			win.atTop <= atTop;
			win.atBottom <= atBottom;
			win.atLeft <= atLeft;
			win.atRight <= atRight;
			win.site <= site;
			win.x <= centerX;
			win.y <= centerY;
		end
	end

endmodule

/* rtl/bayerWindowIf.sv */
interface bayerWindowIf
	import demosaicPkg::*;
();

	// Row 0 is the upper row, column 0 the left column
	PixelT [0:2][0:2] window;
	logic atTop;
	logic atBottom;
	logic atLeft;
	logic atRight;
	SiteT site;
	CoordT x;
	CoordT y;
	logic valid;
	logic frameEnd;

	modport source (
		output window, atTop, atBottom, atLeft, atRight,
		output site, x, y, valid, frameEnd
	);

	modport sink (
		input window, atTop, atBottom, atLeft, atRight,
		input site, x, y, valid, frameEnd
	);

endinterface

/* rtl/demosaicGreen.sv */
module demosaicGreen
	import demosaicPkg::*;
#(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080
) (
	input logic clk,
	input logic reset,
	input PixelT bayer,
	input logic bayerValid,
	output PixelT red,
	output PixelT green,
	output PixelT blue,
	output logic rgbValid,
	output CoordT xPos,
	output CoordT yPos,
	output logic frameDone,
	output ThresholdT threshold
);

	CoordT centerX;
	CoordT centerY;
	logic centerValid;
	logic frameEnd;
	ActivityT activitySample;
	logic sampleValid;

	bayerWindowIf windowBus ();

	rasterCounter #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight)
	) counter (
		.clk(clk),
		.reset(reset),
		.bayerValid(bayerValid),
		.centerX(centerX),
		.centerY(centerY),
		.centerValid(centerValid),
		.frameEnd(frameEnd)
	);

	bayerWindow #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight)
	) windowGen (
		.clk(clk),
		.reset(reset),
		.bayer(bayer),
		.bayerValid(bayerValid),
		.centerX(centerX),
		.centerY(centerY),
		.centerValid(centerValid),
		.frameEnd(frameEnd),
		.win(windowBus.source)
	);

	greenEstimator estimator (
		.clk(clk),
		.reset(reset),
		.bayerValid(bayerValid),
		.win(windowBus.sink),
		.red(red),
		.green(green),
		.blue(blue),
		.rgbValid(rgbValid),
		.xPos(xPos),
		.yPos(yPos),
		.activitySample(activitySample),
		.sampleValid(sampleValid),
		.frameDone(frameDone)
	);

	activityThreshold thresholdGen (
		.clk(clk),
		.reset(reset),
		.activitySample(activitySample),
		.sampleValid(sampleValid),
		.frameDone(frameDone),
		.threshold(threshold)
	);

endmodule

/* rtl/demosaicPkg.sv */
package demosaicPkg;

	typedef logic [7:0] PixelT;
	typedef logic [15:0] CoordT;
	typedef logic [31:0] ActivityT;
	typedef logic [7:0] ThresholdT;

	// Colour of the raw sample at a mosaic site
	typedef enum logic [1:0] {
		SiteGreen,
		SiteBlue,
		SiteRed
	} SiteT;

	// Enabled beats from the window centre to the registered output
	localparam int PipeDepth = 4;

	// Edge threshold used until the first frame has been measured
	localparam int ThresholdReset = 8;

	// Ascending activity bounds for small frames
	localparam ActivityT [3:0] ActivityBound = {
		32'd4096,
		32'd2048,
		32'd1024,
		32'd256
	};

	// Level i applies below bound i, the last one above all bounds
	localparam ThresholdT [4:0] ThresholdLevel = {
		8'd8,
		8'd15,
		8'd20,
		8'd40,
		8'd50
	};

endpackage

/* rtl/greenEstimator.sv */
module greenEstimator
	import demosaicPkg::*;
(
	input logic clk,
	input logic reset,
	input logic bayerValid,
	bayerWindowIf.sink win,
	output PixelT red,
	output PixelT green,
	output PixelT blue,
	output logic rgbValid,
	output CoordT xPos,
	output CoordT yPos,
	output ActivityT activitySample,
	output logic sampleValid,
	output logic frameDone
);

	// Direct neighbours, already zero outside the frame
	PixelT left;
	PixelT right;
	PixelT up;
	PixelT down;

	// Gradient stage
	PixelT gradH;
	PixelT gradV;
	PixelT estH;
	PixelT estV;
	PixelT center2;
	SiteT site2;
	CoordT x2;
	CoordT y2;
	logic valid2;
	logic frameEnd2;

	// Selection stage
	PixelT greenSel;
	PixelT center3;
	SiteT site3;
	CoordT x3;
	CoordT y3;
	logic valid3;
	logic frameEnd3;

	function automatic PixelT absDiff(PixelT a, PixelT b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic PixelT floorMean(PixelT a, PixelT b);
		logic [8:0] total;
		total = {1'b0, a} + {1'b0, b};
		return total[8:1];
	endfunction

	assign left = win.window[1][0];
	assign right = win.window[1][2];
	assign up = win.window[0][1];
	assign down = win.window[2][1];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid2 <= 1'b0;
			frameEnd2 <= 1'b0;
			valid3 <= 1'b0;
			frameEnd3 <= 1'b0;
		end else if (bayerValid) begin
			valid2 <= win.valid;
			frameEnd2 <= win.frameEnd;
			valid3 <= valid2;
			frameEnd3 <= frameEnd2;
		end
	end

	always_ff @(posedge clk) begin
		if (bayerValid) begin
			gradH <= absDiff(left, right);
			gradV <= absDiff(up, down);
			// At a border the one real neighbour is the estimate
			if (win.atLeft) begin
				estH <= right;
			end else if (win.atRight) begin
				estH <= left;
			end else begin
				estH <= floorMean(left, right);
			end
			if (win.atTop) begin
				estV <= down;
			end else if (win.atBottom) begin
				estV <= up;
			end else begin
				estV <= floorMean(up, down);
			end
			center2 <= win.window[1][1];
			site2 <= win.site;
			x2 <= win.x;
			y2 <= win.y;

			// Interpolate along the direction with the smaller gradient
			if (gradH > gradV) begin
				greenSel <= estV;
			end else if (gradH < gradV) begin
				greenSel <= estH;
			end else begin
				greenSel <= floorMean(estH, estV);
			end
			activitySample <= ActivityT'({1'b0, gradH} + {1'b0, gradV});
			center3 <= center2;
			site3 <= site2;
			x3 <= x2;
			y3 <= y2;
		end
	end

	// Pulses last one cycle and only follow a beat
	always_ff @(posedge clk) begin
		if (reset) begin
			sampleValid <= 1'b0;
			rgbValid <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			sampleValid <= bayerValid && valid2 && (site2 != SiteGreen);
			rgbValid <= bayerValid && valid3;
			frameDone <= bayerValid && valid3 && frameEnd3;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			red <= '0;
			green <= '0;
			blue <= '0;
			xPos <= '0;
			yPos <= '0;
		end else if (bayerValid && valid3) begin
			xPos <= x3;
			yPos <= y3;
			case (site3)
				SiteBlue: begin
					red <= '0;
					green <= greenSel;
					blue <= center3;
				end
				SiteRed: begin
					red <= center3;
					green <= greenSel;
					blue <= '0;
				end
				default: begin
					red <= '0;
					green <= center3;
					blue <= '0;
				end
			endcase
		end
	end

endmodule

/* rtl/rasterCounter.sv */
module rasterCounter
	import demosaicPkg::*;
#(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080
) (
	input logic clk,
	input logic reset,
	input logic bayerValid,
	output CoordT centerX,
	output CoordT centerY,
	output logic centerValid,
	output logic frameEnd
);

	// Pixels, one row plus one pixel of flush, then the pipeline drain
	localparam int FrameBeats = frameWidth * frameHeight + frameWidth + 1 + PipeDepth;
	localparam int CountBits = $clog2(FrameBeats);
	// Pixel k sits in the centre register during beat k + frameWidth + 2
	localparam int FirstCenter = frameWidth + 2;
	localparam int LastCenter = FirstCenter + frameWidth * frameHeight - 1;

	logic [CountBits-1:0] beatCount;

	always_ff @(posedge clk) begin
		if (reset) begin
			beatCount <= '0;
		end else if (bayerValid) begin
			if (beatCount == CountBits'(FrameBeats - 1)) begin
				beatCount <= '0;
			end else begin
				beatCount <= beatCount + 1'b1;
			end
		end
	end

	assign centerValid = (beatCount >= CountBits'(FirstCenter)) &&
		(beatCount <= CountBits'(LastCenter));
	assign frameEnd = (beatCount == CountBits'(LastCenter));

	// Raster position of the pixel now in the centre
	always_ff @(posedge clk) begin
		if (reset) begin
			centerX <= '0;
			centerY <= '0;
		end else if (bayerValid && centerValid) begin
			if (centerX == CoordT'(frameWidth - 1)) begin
				centerX <= '0;
				if (centerY == CoordT'(frameHeight - 1)) begin
					centerY <= '0;
				end else begin
					centerY <= centerY + 1'b1;
				end
			end else begin
				centerX <= centerX + 1'b1;
			end
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module demosaicGreenTb -f demosaicGreen.f && \
	./obj_dir/VdemosaicGreenTb +verilator+error+limit+1000 | tee /dev/stderr | \
	grep -x "Testbench passed" > /dev/null && \
	echo "Simulation result: PASS" || \
	{ echo "Simulation result: FAIL"; exit 1; }

/* tests/demosaicGreenTb.sv */
module demosaicGreenTb
	import demosaicPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int Width = 8;
	localparam int Height = 6;
	localparam int Pixels = Width * Height;
	// Pixels, one row and one pixel of flush, then the pipeline drain
	localparam int BeatsPerFrame = Pixels + Width + 1 + PipeDepth;
	localparam int Frames = 4;
	localparam int MaxGap = 3;
	localparam int ClockPeriod = 4;
	localparam int WatchdogCycles = Frames * BeatsPerFrame * (MaxGap + 1) + 200;

	logic clk;
	logic reset;
	PixelT bayer;
	logic bayerValid;
	PixelT red;
	PixelT green;
	PixelT blue;
	logic rgbValid;
	CoordT xPos;
	CoordT yPos;
	logic frameDone;
	ThresholdT threshold;

	int frame [Height][Width];
	logic [31:0] lfsrState;
	logic idleCheck;
	// Each entry is {x, y, red, green, blue}
	logic [55:0] expectedPixels [$];
	int expectedThresholds [$];
	int valueErrors = 0;
	int protocolErrors = 0;
	int pulseCount = 0;
	logic thresholdDue = 1'b0;
	// Whether the last rising edge saw a beat
	logic lastBeat = 1'b0;

	demosaicGreen #(
		.frameWidth(Width),
		.frameHeight(Height)
	) UUT (
		.clk(clk),
		.reset(reset),
		.bayer(bayer),
		.bayerValid(bayerValid),
		.red(red),
		.green(green),
		.blue(blue),
		.rgbValid(rgbValid),
		.xPos(xPos),
		.yPos(yPos),
		.frameDone(frameDone),
		.threshold(threshold)
	);

	initial begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] galoisStep(logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h80200003;
		end
		return next;
	endfunction

	// One LFSR step per bit taken
	function automatic int randomBits(int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = galoisStep(lfsrState);
		end
		return value;
	endfunction

	// Neighbours outside the frame read as 0
	function automatic int pixelAt(int x, int y);
		if (x < 0 || x >= Width || y < 0 || y >= Height) begin
			return 0;
		end
		return frame[y][x];
	endfunction

	function automatic int absValue(int a);
		return (a < 0) ? -a : a;
	endfunction

	function automatic logic [55:0] expectedRgb(int x, int y);
		int l;
		int r;
		int u;
		int d;
		int h;
		int v;
		int gH;
		int gV;
		int g;
		int raw;
		l = pixelAt(x - 1, y);
		r = pixelAt(x + 1, y);
		u = pixelAt(x, y - 1);
		d = pixelAt(x, y + 1);
		h = absValue(l - r);
		v = absValue(u - d);
		gH = (x == 0) ? r : (x == Width - 1) ? l : (l + r) / 2;
		gV = (y == 0) ? d : (y == Height - 1) ? u : (u + d) / 2;
		if (h > v) begin
			g = gV;
		end else if (h < v) begin
			g = gH;
		end else begin
			g = (gH + gV) / 2;
		end
		raw = frame[y][x];
		if ((x % 2) == (y % 2)) begin
			return {CoordT'(x), CoordT'(y), 8'd0, PixelT'(raw), 8'd0};
		end else if ((y % 2) == 0) begin
			return {CoordT'(x), CoordT'(y), 8'd0, PixelT'(g), PixelT'(raw)};
		end
		return {CoordT'(x), CoordT'(y), PixelT'(raw), PixelT'(g), 8'd0};
	endfunction

	// Sum of h + v over the red and blue sites
	function automatic int frameActivity();
		int sum;
		sum = 0;
		for (int y = 0; y < Height; y++) begin
			for (int x = 0; x < Width; x++) begin
				if ((x % 2) != (y % 2)) begin
					sum += absValue(pixelAt(x - 1, y) - pixelAt(x + 1, y)) +
						absValue(pixelAt(x, y - 1) - pixelAt(x, y + 1));
				end
			end
		end
		return sum;
	endfunction

	function automatic int expectedThreshold(int activity);
		if (activity < 256) begin
			return 50;
		end else if (activity < 1024) begin
			return 40;
		end else if (activity < 2048) begin
			return 20;
		end else if (activity < 4096) begin
			return 15;
		end
		return 8;
	endfunction

	task automatic checkValue(input string name, input int actual, input int expected);
		assert (actual == expected) else begin
			valueErrors++;
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	// Idle cycles first when gaps are on, then one beat
	task automatic driveBeat(input int value, input logic withGaps);
		int gap;
		gap = withGaps ? randomBits(2) : 0;
		repeat (gap) begin
			bayerValid = 1'b0;
			bayer = PixelT'(randomBits(8));
			@(posedge clk);
			#1;
		end
		bayer = PixelT'(value);
		bayerValid = 1'b1;
		@(posedge clk);
		#1;
	endtask

	// A zero mask gives a flat frame of flatValue
	task automatic sendFrame(input int flatValue, input int mask, input logic withGaps);
		for (int y = 0; y < Height; y++) begin
			for (int x = 0; x < Width; x++) begin
				frame[y][x] = (mask == 0) ? flatValue : (randomBits(8) & mask);
			end
		end
		for (int y = 0; y < Height; y++) begin
			for (int x = 0; x < Width; x++) begin
				expectedPixels.push_back(expectedRgb(x, y));
			end
		end
		expectedThresholds.push_back(expectedThreshold(frameActivity()));
		for (int y = 0; y < Height; y++) begin
			for (int x = 0; x < Width; x++) begin
				driveBeat(frame[y][x], withGaps);
			end
		end
		// Flush beats carry arbitrary data
		repeat (BeatsPerFrame - Pixels) begin
			driveBeat(randomBits(8), withGaps);
		end
	endtask

	// Outputs are sampled mid-cycle, away from the rising edge
	always @(negedge clk) begin
		logic [55:0] expected;
		if (idleCheck) begin
			checkValue("rgbValid", int'(rgbValid), 0);
			checkValue("frameDone", int'(frameDone), 0);
			checkValue("threshold", int'(threshold), 8);
			checkValue("red", int'(red), 0);
			checkValue("green", int'(green), 0);
			checkValue("blue", int'(blue), 0);
			checkValue("xPos", int'(xPos), 0);
			checkValue("yPos", int'(yPos), 0);
		end
		if (thresholdDue) begin
			thresholdDue = 1'b0;
			assert (expectedThresholds.size() > 0) else begin
				protocolErrors++;
				$display("Threshold update at %0t with no frame pending", $time);
			end
			if (expectedThresholds.size() > 0) begin
				checkValue("threshold", int'(threshold), expectedThresholds.pop_front());
			end
		end
		if (rgbValid) begin
			assert (lastBeat) else begin
				protocolErrors++;
				$display("rgbValid at %0t rose after a cycle without a beat", $time);
			end
			assert (expectedPixels.size() > 0 && pulseCount < Pixels) else begin
				protocolErrors++;
				$display("Output pixel at %0t beyond the pixels of the frame", $time);
			end
			if (expectedPixels.size() > 0) begin
				expected = expectedPixels.pop_front();
				checkValue("xPos", int'(xPos), int'(expected[55:40]));
				checkValue("yPos", int'(yPos), int'(expected[39:24]));
				checkValue("red", int'(red), int'(expected[23:16]));
				checkValue("green", int'(green), int'(expected[15:8]));
				checkValue("blue", int'(blue), int'(expected[7:0]));
			end
			pulseCount++;
		end
		if (frameDone) begin
			assert (rgbValid && pulseCount == Pixels) else begin
				protocolErrors++;
				$display("frameDone at %0t did not come with the last pixel of the frame", $time);
			end
			pulseCount = 0;
			thresholdDue = 1'b1;
		end
		// The next rising edge samples the value driven now
		lastBeat = bayerValid;
	end

	initial begin
		int missing;
		int assertionFails;
		lfsrState = 32'h65f340c9;
		reset = 1'b1;
		bayer = '0;
		bayerValid = 1'b0;
		idleCheck = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		idleCheck = 1'b1;
		repeat (6) @(posedge clk);
		#1;
		idleCheck = 1'b0;

		// Flat frame of 18 keeps the border activity just under 256
		sendFrame(18, 0, 1'b0);
		sendFrame(0, 8'hff, 1'b0);
		sendFrame(0, 8'h3f, 1'b1);
		sendFrame(0, 8'h0f, 1'b1);
		bayerValid = 1'b0;
		repeat (8) @(posedge clk);

		missing = expectedPixels.size() + expectedThresholds.size();
		assert (missing == 0) else begin
			$display("%0d expected outputs never arrived", missing);
		end
		assertionFails = UUT.estimator.estimatorCheck.failCount;
		$display("Summary: %0d value errors, %0d protocol errors, %0d missing, %0d assertion",
			valueErrors, protocolErrors, missing, assertionFails);
		if (valueErrors + protocolErrors + missing + assertionFails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(WatchdogCycles * ClockPeriod);
		$display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* tests/demosaicGreen_assert.sv */
module estimatorChecker
	import demosaicPkg::*;
(
	input logic clk,
	input logic reset,
	input logic windowValid,
	input logic windowFrameEnd,
	input logic atTop,
	input logic atBottom,
	input logic atLeft,
	input logic atRight,
	input PixelT left,
	input PixelT right,
	input PixelT up,
	input PixelT down,
	input logic sampleValid,
	input logic frameDone
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failures over all properties
	int failCount = 0;

	// The frame end marker rides on the bottom right pixel of the frame
	frameEndAtCorner: assert property (
		@(posedge clk) disable iff (reset)
			windowFrameEnd |-> windowValid && atBottom && atRight
	) else begin
		failCount++;
		$error("Window frame end away from the last pixel of the frame");
	end

	// Neighbours beyond a flagged border arrive as zero
	borderMasked: assert property (
		@(posedge clk) disable iff (reset) windowValid |->
			(!atLeft || left == '0) && (!atRight || right == '0) &&
			(!atTop || up == '0) && (!atBottom || down == '0)
	) else begin
		failCount++;
		$error("Window neighbour outside the frame is not zero");
	end

	// The activity sum takes no sample in the clock that loads the threshold
	sampleApartFromDone: assert property (
		@(posedge clk) disable iff (reset) !(sampleValid && frameDone)
	) else begin
		failCount++;
		$error("Activity sample coincides with frameDone");
	end

endmodule

bind greenEstimator estimatorChecker estimatorCheck (
	.clk(clk),
	.reset(reset),
	.windowValid(win.valid),
	.windowFrameEnd(win.frameEnd),
	.atTop(win.atTop),
	.atBottom(win.atBottom),
	.atLeft(win.atLeft),
	.atRight(win.atRight),
	.left(left),
	.right(right),
	.up(up),
	.down(down),
	.sampleValid(sampleValid),
	.frameDone(frameDone)
);
